// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the mixer testbench with Verilator, run it, and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mixer_tb -f sim.f -o mixer_sim \
  && ./obj_dir/mixer_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
verilog/mixer_pkg.sv
verilog/q_multiplier.sv
verilog/mixer_channel.sv
verilog/mix_bus.sv
verilog/master_stage.sv
verilog/clip_status.sv
verilog/mixer_top.sv
testbench/mixer_tb.sv

// ==== testbench/mixer_tb.sv ====
// mixer_tb: clock, reset, stimulus, reference model, output assertions and report

`timescale 1ns/1ps

module mixer_tb
  import mixer_pkg::*;
();

  localparam int     SEED    = 67153;
  localparam int     LATENCY = 7;   // sample_valid to out_valid
  localparam int     TIMEOUT = 40;  // cycles allowed per wait
  localparam longint LIM_HI  = (longint'(1) << (AUDIO_WIDTH - 1)) - 1;
  localparam longint LIM_LO  = -(longint'(1) << (AUDIO_WIDTH - 1));

  logic    clk;
  logic    rst_n;
  sample_t x_in    [N_CHANNELS];
  logic    sample_valid;
  gain_t   gain_in [N_CHANNELS];
  gain_t   pan_in  [N_CHANNELS];
  gain_t   master_in;
  logic    clip_clear;
  sample_t out_left;
  sample_t out_right;
  logic    out_valid;
  clip_t   sr_clip;

  int      cycle = 0;
  int      error_count = 0;
  int      err_mark;       // error count when the test began
  int      tests_passed = 0;
  int      tests_failed = 0;
  string   test_name = "startup";
  longint  exp_left_q [$];  // model results, oldest first
  longint  exp_right_q [$];
  int      due_q [$];       // cycle each result is due
  clip_t   exp_clip;        // sticky status the model predicts
  sample_t last_left;
  sample_t last_right;

  mixer_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .x              (x_in),
    .sample_valid   (sample_valid),
    .cr_gain        (gain_in),
    .cr_pan         (pan_in),
    .cr_master_gain (master_in),
    .cr_clip_clear  (clip_clear),
    .out_left       (out_left),
    .out_right      (out_right),
    .out_valid      (out_valid),
    .sr_clip        (sr_clip)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////
  // reference arithmetic
  ////////////////////////////////////////////////////////////

  // q2.14 scale, floor through the arithmetic shift
  function automatic longint scale_q(longint s, longint g);
    return (s * g) >>> Q_BITS;
  endfunction

  function automatic bit exceeds(longint v);
    return (v > LIM_HI) || (v < LIM_LO);
  endfunction

  function automatic longint clamp_audio(longint v);
    if (v > LIM_HI) return LIM_HI;
    if (v < LIM_LO) return LIM_LO;
    return v;
  endfunction

  // uniform in -2^(bits-1) .. 2^(bits-1)-1
  function automatic sample_t rand_sample(int bits);
    longint v;
    v = longint'($urandom % (32'd1 << bits)) - (longint'(1) << (bits - 1));
    return sample_t'(v);
  endfunction

  task automatic check_value(input string what, input longint expected, input longint actual);
    assert (expected == actual) else begin
      $display("mismatch %s %s: expected %0d actual %0d", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output checker, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      assert (due_q.size() > 0 && due_q[0] == cycle) else begin
        $display("%s: out_valid high in cycle %0d with no result due", test_name, cycle);
        error_count++;
      end
      if (due_q.size() > 0) begin
        check_value("out_left", exp_left_q.pop_front(), longint'(out_left));
        check_value("out_right", exp_right_q.pop_front(), longint'(out_right));
        void'(due_q.pop_front());
      end
      last_left  = out_left;
      last_right = out_right;
    end else if (rst_n && due_q.size() > 0) begin
      assert (due_q[0] > cycle) else begin  // result due but no valid
        $display("%s: out_valid missing in cycle %0d", test_name, cycle);
        error_count++;
        void'(exp_left_q.pop_front());
        void'(exp_right_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks, all return 1 ns past a rising edge
  ////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic set_controls(input gain_t g, input gain_t p, input gain_t m);
    for (int i = 0; i < N_CHANNELS; i++) begin
      gain_in[i] = g;
      pan_in[i]  = p;
    end
    master_in = m;
  endtask

  task automatic random_samples(input int bits);
    for (int i = 0; i < N_CHANNELS; i++) x_in[i] = rand_sample(bits);
  endtask

  // model the frame on x_in and the held controls, then strobe it in
  task automatic send_frame();
    longint g, pr, l, r;
    longint sum_l, sum_r, bl, br, ol, orr;
    clip_t  bits;
    bits  = '0;
    sum_l = 0;
    sum_r = 0;
    for (int i = 0; i < N_CHANNELS; i++) begin
      g       = scale_q(longint'(x_in[i]), longint'(gain_in[i]));  // channel gain
      bits[i] = exceeds(g);
      g       = clamp_audio(g);
      pr      = (pan_in[i] > GAIN_ONE) ? 0 : longint'(GAIN_ONE) - longint'(pan_in[i]);
      l       = scale_q(g, longint'(pan_in[i]));
      r       = scale_q(g, pr);
      bits[i] = bits[i] | exceeds(l) | exceeds(r);
      sum_l  += clamp_audio(l);
      sum_r  += clamp_audio(r);
    end
    bits[N_CHANNELS] = exceeds(sum_l) | exceeds(sum_r);  // bus
    bl  = clamp_audio(sum_l);
    br  = clamp_audio(sum_r);
    ol  = scale_q(bl, longint'(master_in));
    orr = scale_q(br, longint'(master_in));
    bits[N_CHANNELS+1] = exceeds(ol) | exceeds(orr);     // master
    exp_left_q.push_back(clamp_audio(ol));
    exp_right_q.push_back(clamp_audio(orr));
    due_q.push_back(cycle + LATENCY);
    exp_clip |= bits;
    sample_valid = 1'b1;
    step();
    sample_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (due_q.size() > 0 && n < TIMEOUT) begin
      step();
      n++;
    end
    if (due_q.size() > 0) begin
      $display("%s: timeout, %0d results never arrived", test_name, due_q.size());
      error_count++;
    end
    step();  // last clip pulse lands in sr_clip
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    while (!out_valid && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!out_valid) begin
      $display("%s: timeout waiting for out_valid", test_name);
      error_count++;
    end
  endtask

  task automatic pulse_clear();
    clip_clear = 1'b1;
    exp_clip   = '0;
    step();
    clip_clear = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = error_count;
  endtask

  task automatic end_test();
    if (error_count == err_mark) begin
      tests_passed++;
      $display("test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", test_name, error_count - err_mark);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int sent;
    void'($urandom(SEED));
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    clip_clear   = 1'b0;
    exp_clip     = '0;
    set_controls(GAIN_ONE, GAIN_ONE >> 1, GAIN_ONE);
    for (int i = 0; i < N_CHANNELS; i++) x_in[i] = '0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    begin_test("reset_latency");
    check_value("out_valid", 0, longint'(out_valid));
    check_value("sr_clip", 0, longint'(sr_clip));
    check_value("out_left", 0, longint'(out_left));
    random_samples(21);
    sent = cycle;
    send_frame();
    wait_out_valid();
    check_value("latency", longint'(LATENCY), longint'(cycle - sent));
    drain();
    end_test();

    begin_test("pan_extremes");
    set_controls(GAIN_ONE, GAIN_ONE, GAIN_ONE);  // hard left
    random_samples(21);
    send_frame();
    drain();
    check_value("right_silent", 0, longint'(last_right));
    set_controls(GAIN_ONE, '0, GAIN_ONE);        // hard right
    send_frame();
    drain();
    check_value("left_silent", 0, longint'(last_left));
    set_controls(GAIN_ONE, gain_t'(GAIN_ONE + 2000), GAIN_ONE);  // past unity
    send_frame();
    drain();
    check_value("right_clamped", 0, longint'(last_right));
    end_test();

    begin_test("streaming");
    pulse_clear();
    for (int i = 0; i < N_CHANNELS; i++) begin
      gain_in[i] = gain_t'($urandom % GAIN_ONE);
      pan_in[i]  = gain_t'($urandom % (32'(GAIN_ONE) + 32'd1));
    end
    master_in = gain_t'($urandom % (32'(GAIN_ONE) + 32'd1));
    for (int f = 0; f < 64; f++) begin  // back to back, valid never drops
      random_samples(22);
      send_frame();
    end
    drain();
    check_value("sr_clip", 0, longint'(sr_clip));
    end_test();

    begin_test("channel_clip");
    pulse_clear();
    set_controls(GAIN_ONE, GAIN_ONE >> 1, GAIN_ONE);
    random_samples(20);
    x_in[2]    = sample_t'(3000000);
    gain_in[2] = 16'hFFFF;  // nearly 4x, saturates channel 2
    send_frame();
    drain();
    check_value("sr_clip", longint'(exp_clip), longint'(sr_clip));
    end_test();

    begin_test("bus_master_sat");
    pulse_clear();
    set_controls(GAIN_ONE, GAIN_ONE, GAIN_ONE);
    for (int i = 0; i < N_CHANNELS; i++) x_in[i] = SAMPLE_MAX;  // bus overflow
    send_frame();
    drain();
    check_value("left_limit", LIM_HI, longint'(last_left));
    check_value("sr_clip", longint'(exp_clip), longint'(sr_clip));
    for (int i = 0; i < N_CHANNELS; i++) x_in[i] = '0;
    x_in[0]   = SAMPLE_MIN;
    master_in = 16'hFFFF;  // master overflow
    send_frame();
    drain();
    check_value("left_limit", LIM_LO, longint'(last_left));
    check_value("sr_clip", longint'(exp_clip), longint'(sr_clip));
    end_test();

    begin_test("clip_clear");
    pulse_clear();
    check_value("sr_clip", 0, longint'(sr_clip));
    master_in = GAIN_ONE;
    for (int i = 0; i < N_CHANNELS; i++) x_in[i] = SAMPLE_MAX;
    send_frame();  // sets the bus bit
    drain();
    check_value("sr_clip", longint'(exp_clip), longint'(sr_clip));
    for (int i = 0; i < N_CHANNELS; i++) x_in[i] = '0;
    x_in[0]   = SAMPLE_MIN;
    master_in = 16'hFFFF;
    exp_clip  = '0;  // clear below lands before the master bit
    send_frame();
    wait_out_valid();
    clip_clear = 1'b1;  // same edge as the master clip pulse
    step();
    clip_clear = 1'b0;
    check_value("sr_clip", longint'(exp_clip), longint'(sr_clip));
    drain();
    end_test();

    $display("summary: %0d ok, %0d failing, %0d errors", tests_passed, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/clip_status.sv ====
// clip_status: sticky clip bits for channels, bus and master with clear strobe

`timescale 1ns/1ps

module clip_status
  import mixer_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [N_CHANNELS-1:0] ch_clip,      // one pulse per channel
  input  logic                  bus_clip,
  input  logic                  master_clip,
  input  logic                  clear,        // software strobe
  output clip_t                 sr_clip
);

  clip_t set_bits;  // this cycle's clip pulses
  clip_t kept_bits; // old bits surviving a clear

  ////////////////////////////////////////////////////////////
  // bit layout
  ////////////////////////////////////////////////////////////

  // [N_CHANNELS-1:0] channels, then bus, then master on top
  assign set_bits = {master_clip, bus_clip, ch_clip};

  // clear drops old bits only
  assign kept_bits = clear ? '0 : sr_clip;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sr_clip <= '0;
    end else begin
      sr_clip <= kept_bits | set_bits;  // new set beats clear
    end
  end

endmodule

// ==== verilog/master_stage.sv ====
// master_stage: two-cycle shared master gain on the stereo pair

`timescale 1ns/1ps

module master_stage
  import mixer_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // bus pair in
  input  sample_t in_left,
  input  sample_t in_right,
  input  logic    in_valid,

  // shared gain, taken as the frame enters
  input  gain_t   cr_master_gain,

  // final pair out
  output sample_t out_left,
  output sample_t out_right,
  output logic    out_valid,
  output logic    clip
);

  logic left_ovf;
  logic right_ovf;

  ////////////////////////////////////////////////////////////
  // one multiplier per side
  ////////////////////////////////////////////////////////////

  q_multiplier u_master_left (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .multiplicand (in_left),
    .multiplier   (cr_master_gain),
    .product      (out_left),
    .out_valid    (out_valid),    // left carries the pair's valid
    .overflow     (left_ovf)
  );

  q_multiplier u_master_right (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .multiplicand (in_right),
    .multiplier   (cr_master_gain),
    .product      (out_right),
    .out_valid    (),             // identical to left
    .overflow     (right_ovf)
  );

  // master clips if either side clamped
  assign clip = left_ovf | right_ovf;

endmodule

// ==== verilog/mix_bus.sv ====
// mix_bus: one-cycle per-side sum of all channels with saturation and clip flag

`timescale 1ns/1ps

module mix_bus
  import mixer_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  sample_t in_left  [N_CHANNELS],
  input  sample_t in_right [N_CHANNELS],
  input  logic    in_valid,             // channel 0 valid, all in lockstep
  output sample_t sum_left,
  output sample_t sum_right,
  output logic    sum_valid,
  output logic    clip
);

  acc_t    acc_left;   // exact sums, two guard bits
  acc_t    acc_right;
  logic    clamp_left;
  logic    clamp_right;
  sample_t sat_left;
  sample_t sat_right;

  ////////////////////////////////////////////////////////////
  // exact sum and clamp
  ////////////////////////////////////////////////////////////

  always_comb begin
    acc_left  = '0;
    acc_right = '0;
    for (int i = 0; i < N_CHANNELS; i++) begin
      acc_left  = acc_left  + acc_t'(in_left[i]);   // sign-extended
      acc_right = acc_right + acc_t'(in_right[i]);
    end

    clamp_left  = (acc_left  > acc_t'(SAMPLE_MAX)) || (acc_left  < acc_t'(SAMPLE_MIN));
    clamp_right = (acc_right > acc_t'(SAMPLE_MAX)) || (acc_right < acc_t'(SAMPLE_MIN));

    // sign bit picks the limit
    sat_left  = clamp_left  ? (acc_left[ACC_WIDTH-1]  ? SAMPLE_MIN : SAMPLE_MAX)
                            : acc_left[AUDIO_WIDTH-1:0];
    sat_right = clamp_right ? (acc_right[ACC_WIDTH-1] ? SAMPLE_MIN : SAMPLE_MAX)
                            : acc_right[AUDIO_WIDTH-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_left  <= '0;
      sum_right <= '0;
      sum_valid <= 1'b0;
      clip      <= 1'b0;
    end else begin
      sum_valid <= in_valid;
      clip      <= in_valid & (clamp_left | clamp_right);  // either side
      if (in_valid) begin
        sum_left  <= sat_left;
        sum_right <= sat_right;
      end
    end
  end

endmodule

// ==== verilog/mixer_channel.sv ====
// mixer_channel: per-channel gain multiply, then parallel left/right pan multiplies

`timescale 1ns/1ps

module mixer_channel
  import mixer_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // sample in
  input  sample_t x,
  input  logic    x_valid,

  // controls
  input  gain_t   cr_gain,
  input  gain_t   cr_pan,

  // panned pair out
  output sample_t y_left,
  output sample_t y_right,
  output logic    y_valid,
  output logic    clip
);

  sample_t x_gain;        // after channel gain
  logic    x_gain_valid;
  logic    gain_ovf;
  gain_t   pan_right;     // derived right pan gain
  logic    left_ovf;
  logic    right_ovf;

  ////////////////////////////////////////////////////////////
  // channel gain, cycles 1-2
  ////////////////////////////////////////////////////////////

  q_multiplier u_gain_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (x_valid),
    .multiplicand (x),
    .multiplier   (cr_gain),
    .product      (x_gain),
    .out_valid    (x_gain_valid),
    .overflow     (gain_ovf)
  );

  ////////////////////////////////////////////////////////////
  // pan split, cycles 3-4
  ////////////////////////////////////////////////////////////

  // right = unity - pan, floored at zero once pan passes unity
  assign pan_right = (cr_pan > GAIN_ONE) ? '0 : GAIN_ONE - cr_pan;

  q_multiplier u_pan_left (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (x_gain_valid),
    .multiplicand (x_gain),
    .multiplier   (cr_pan),      // left gain is pan itself
    .product      (y_left),
    .out_valid    (y_valid),     // both sides in lockstep
    .overflow     (left_ovf)
  );

  q_multiplier u_pan_right (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (x_gain_valid),
    .multiplicand (x_gain),
    .multiplier   (pan_right),
    .product      (y_right),
    .out_valid    (),            // same as left valid
    .overflow     (right_ovf)
  );

  // overflows already carry their valid
  assign clip = gain_ovf | left_ovf | right_ovf;

endmodule

// ==== verilog/mixer_pkg.sv ====
// mixer package: widths, q format constants, channel count, sample/gain/clip types

package mixer_pkg;

  ////////////////////////////////////////////////////////////
  // widths and q format
  ////////////////////////////////////////////////////////////

  localparam int AUDIO_WIDTH = 24;  // signed sample
  localparam int GAIN_WIDTH  = 16;  // unsigned gain or pan
  localparam int Q_BITS      = 14;  // gain is Q2.14
  localparam int N_CHANNELS  = 4;
  localparam int CLIP_WIDTH  = N_CHANNELS + 2;  // channels, bus, master

  // full multiply, one extra bit for the zero-extended gain
  localparam int PRODUCT_WIDTH = AUDIO_WIDTH + GAIN_WIDTH + 1;
  // four-way sum needs two guard bits
  localparam int ACC_WIDTH     = AUDIO_WIDTH + 2;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic signed [AUDIO_WIDTH-1:0]   sample_t;
  typedef logic        [GAIN_WIDTH-1:0]    gain_t;
  typedef logic        [CLIP_WIDTH-1:0]    clip_t;
  typedef logic signed [PRODUCT_WIDTH-1:0] product_t;  // multiplier internal
  typedef logic signed [ACC_WIDTH-1:0]     acc_t;      // bus accumulator

  ////////////////////////////////////////////////////////////
  // typed constants
  ////////////////////////////////////////////////////////////

  localparam gain_t   GAIN_ONE   = gain_t'(1) << Q_BITS;  // 16384, unity
  localparam sample_t SAMPLE_MAX = {1'b0, {(AUDIO_WIDTH-1){1'b1}}};  // +2^23-1
  localparam sample_t SAMPLE_MIN = {1'b1, {(AUDIO_WIDTH-1){1'b0}}};  // -2^23

endpackage

// ==== verilog/mixer_top.sv ====
// mixer_top: four channels, mix bus, master stage and clip status chained

`timescale 1ns/1ps

module mixer_top
  import mixer_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // frame in, one sample per channel
  input  sample_t x [N_CHANNELS],
  input  logic    sample_valid,

  // control levels
  input  gain_t   cr_gain [N_CHANNELS],
  input  gain_t   cr_pan  [N_CHANNELS],
  input  gain_t   cr_master_gain,
  input  logic    cr_clip_clear,

  // stereo out, 7 cycles after sample_valid
  output sample_t out_left,
  output sample_t out_right,
  output logic    out_valid,
  output clip_t   sr_clip
);

  sample_t               ch_left  [N_CHANNELS];
  sample_t               ch_right [N_CHANNELS];
  logic [N_CHANNELS-1:0] ch_valid;
  logic [N_CHANNELS-1:0] ch_clip;

  sample_t bus_left;
  sample_t bus_right;
  logic    bus_valid;
  logic    bus_clip;
  logic    master_clip;

  ////////////////////////////////////////////////////////////
  // channels, 4 cycles
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_CHANNELS; i++) begin : g_channel
    mixer_channel u_channel (
      .clk     (clk),
      .rst_n   (rst_n),
      .x       (x[i]),
      .x_valid (sample_valid),   // shared frame strobe
      .cr_gain (cr_gain[i]),
      .cr_pan  (cr_pan[i]),
      .y_left  (ch_left[i]),
      .y_right (ch_right[i]),
      .y_valid (ch_valid[i]),
      .clip    (ch_clip[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // bus sum, 1 cycle
  ////////////////////////////////////////////////////////////

  mix_bus u_mix_bus (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_left   (ch_left),
    .in_right  (ch_right),
    .in_valid  (ch_valid[0]),    // lockstep, channel 0 stands for all
    .sum_left  (bus_left),
    .sum_right (bus_right),
    .sum_valid (bus_valid),
    .clip      (bus_clip)
  );

  ////////////////////////////////////////////////////////////
  // master gain, 2 cycles
  ////////////////////////////////////////////////////////////

  master_stage u_master_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_left        (bus_left),
    .in_right       (bus_right),
    .in_valid       (bus_valid),
    .cr_master_gain (cr_master_gain),
    .out_left       (out_left),
    .out_right      (out_right),
    .out_valid      (out_valid),
    .clip           (master_clip)
  );

  // sticky status
  clip_status u_clip_status (
    .clk         (clk),
    .rst_n       (rst_n),
    .ch_clip     (ch_clip),
    .bus_clip    (bus_clip),
    .master_clip (master_clip),
    .clear       (cr_clip_clear),
    .sr_clip     (sr_clip)
  );

endmodule

// ==== verilog/q_multiplier.sv ====
// q_multiplier: two-cycle signed sample times unsigned Q gain, floor shift, saturation

`timescale 1ns/1ps

module q_multiplier
  import mixer_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  sample_t multiplicand,
  input  gain_t   multiplier,
  output sample_t product,
  output logic    out_valid,
  output logic    overflow
);

  product_t prod_q;   // full-width product, stage one
  logic     valid_q;  // stage one valid
  product_t shifted;  // prod_q >>> Q_BITS
  logic     sat_hi;
  logic     sat_lo;
  sample_t  clamped;

  ////////////////////////////////////////////////////////////
  // stage one: raw multiply
  ////////////////////////////////////////////////////////////

  // gain is zero-extended by the cast, so the multiply stays signed
  always_ff @(posedge clk) begin
    if (in_valid) begin
      prod_q <= product_t'(multiplicand) * product_t'(multiplier);  // gain taken here
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage two: shift, clamp, flag
  ////////////////////////////////////////////////////////////

  always_comb begin
    shifted = prod_q >>> Q_BITS;  // arithmetic, rounds toward minus infinity
    sat_hi  = shifted > product_t'(SAMPLE_MAX);
    sat_lo  = shifted < product_t'(SAMPLE_MIN);
    if (sat_hi) begin
      clamped = SAMPLE_MAX;
    end else if (sat_lo) begin
      clamped = SAMPLE_MIN;
    end else begin
      clamped = shifted[AUDIO_WIDTH-1:0];  // fits, plain truncation
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      product   <= '0;
      out_valid <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      out_valid <= valid_q;
      overflow  <= valid_q & (sat_hi | sat_lo);  // only with a real frame
      if (valid_q) begin
        product <= clamped;  // holds between frames
      end
    end
  end

endmodule
